// File: src/lcdTimingPkg.sv
package lcdTimingPkg;

    // one counter width covers every wait at 50 MHz
    typedef logic [23:0] cycleCountT;

    // 20 ms before the first command
    localparam cycleCountT powerOnWait = 24'd1_000_000;

    // enable strobe shape
    localparam cycleCountT setupLen = 24'd1;
    localparam cycleCountT enablePulseLen = 24'd27;

    // command execution holds
    localparam cycleCountT hold5ms = 24'd250_000;
    localparam cycleCountT hold150us = 24'd7_500;
    localparam cycleCountT hold50us = 24'd2_500;

    // address and data writes during refresh
    localparam cycleCountT refreshHold = 24'd27;

    // bus cycle engine phases
    localparam logic [1:0] phaseIdle = 2'd0;
    localparam logic [1:0] phaseSetup = 2'd1;
    localparam logic [1:0] phasePulse = 2'd2;
    localparam logic [1:0] phaseHold = 2'd3;

endpackage

// File: src/lcdCmdPkg.sv
package lcdCmdPkg;

    import lcdTimingPkg::*;

    // HD44780 instruction words
    localparam logic [7:0] cmdFunctionSet = 8'h38;
    localparam logic [7:0] cmdDisplayOff = 8'h08;
    localparam logic [7:0] cmdDisplayOn = 8'h0C;
    localparam logic [7:0] cmdDisplayClear = 8'h01;
    localparam logic [7:0] cmdEntryMode = 8'h06;

    // number of commands in the init table
    localparam int initCmdCount = 8;

    // character memory, two lines of 16
    localparam int charDepth = 32;
    localparam int charAddrWidth = 5;
    localparam int lineLen = 16;

    typedef logic [charAddrWidth-1:0] charAddrT;

    // set DDRAM address, line two starts at 0x40
    typedef struct packed {
        logic       setAddr;
        logic       line;
        logic [1:0] zero;
        logic [3:0] column;
    } ddramCmdT;

    typedef union packed {
        logic [7:0] raw;
        ddramCmdT   ddram;
    } lcdWordU;

    typedef struct packed {
        logic       valid;
        lcdWordU    word;
        logic       rs;
        cycleCountT hold;
    } busReqT;

    typedef struct packed {
        logic       strobe;
        charAddrT   addr;
        logic [7:0] code;
    } hostWriteT;

endpackage

// File: src/charMemory.sv
`timescale 1ns/1ns

module charMemory
    import lcdCmdPkg::*;
(
    input  logic       clk,
    input  hostWriteT  hostWrite,
    input  charAddrT   readAddr,
    output logic [7:0] readData
);

    logic [7:0] codes [charDepth];

    // host side write port
    always_ff @(posedge clk)
    begin
        if (hostWrite.strobe)
        begin
            codes[hostWrite.addr] <= hostWrite.code;
        end
    end

    // scanner side, one cycle read latency
    always_ff @(posedge clk)
    begin
        readData <= codes[readAddr];
    end

    // a strobe with a floating address would corrupt an unknown slot
    writeAddrKnown: assert property (
        @(posedge clk) hostWrite.strobe |-> !$isunknown(hostWrite.addr)
    );

endmodule

// File: src/initSequencer.sv
`timescale 1ns/1ns

module initSequencer
    import lcdTimingPkg::*;
    import lcdCmdPkg::*;
(
    input  logic   clk,
    input  logic   lcdOnIn,
    output busReqT req,
    input  logic   done,
    output logic   initDone
);

    cycleCountT waitCount;
    logic [2:0] cmdIndex;
    logic       reqValid;
    lcdWordU    cmdWord;
    cycleCountT cmdHold;

    // init command table
    always_comb
    begin
        case (cmdIndex)
            3'd0:
            begin
                cmdWord.raw = cmdFunctionSet;
                cmdHold = hold5ms;
            end
            3'd1, 3'd2, 3'd3:
            begin
                cmdWord.raw = cmdFunctionSet;
                cmdHold = hold150us;
            end
            3'd4:
            begin
                cmdWord.raw = cmdDisplayOff;
                cmdHold = hold50us;
            end
            3'd5:
            begin
                cmdWord.raw = cmdDisplayClear;
                cmdHold = hold5ms;
            end
            3'd6:
            begin
                cmdWord.raw = cmdEntryMode;
                cmdHold = hold5ms;
            end
            default:
            begin
                cmdWord.raw = cmdDisplayOn;
                cmdHold = hold50us;
            end
        endcase
    end

    // commands are always instructions, rs low
    always_comb
    begin
        req.valid = reqValid;
        req.word = cmdWord;
        req.rs = 1'b0;
        req.hold = cmdHold;
    end

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            waitCount <= '0;
            cmdIndex <= '0;
            reqValid <= 1'b0;
            initDone <= 1'b0;
        end
        else if (!reqValid && !initDone)
        begin
            // power-on wait before the first function set
            if (waitCount == powerOnWait - 1'b1)
            begin
                reqValid <= 1'b1;
            end
            else
            begin
                waitCount <= waitCount + 1'b1;
            end
        end
        else if (reqValid && done)
        begin
            if (cmdIndex == 3'(initCmdCount - 1))
            begin
                reqValid <= 1'b0;
                initDone <= 1'b1;
            end
            else
            begin
                // next command goes out without dropping valid
                cmdIndex <= cmdIndex + 1'b1;
            end
        end
    end

endmodule

// File: src/refreshScanner.sv
`timescale 1ns/1ns

module refreshScanner
    import lcdTimingPkg::*;
    import lcdCmdPkg::*;
(
    input  logic       clk,
    input  logic       lcdOnIn,
    input  logic       initDone,
    output busReqT     req,
    input  logic       done,
    output charAddrT   readAddr,
    input  logic [7:0] readData
);

    charAddrT scanAddr;
    charAddrT nextAddr;
    logic     dataPhase;
    logic     reqValid;
    lcdWordU  reqWord;

    // set DDRAM address for a memory slot
    function automatic lcdWordU addrCommand(charAddrT addr);
        lcdWordU cmd;
        cmd.ddram.setAddr = 1'b1;
        cmd.ddram.line = (addr >= charAddrT'(lineLen));
        cmd.ddram.zero = 2'b00;
        // low bits are the column within the line
        cmd.ddram.column = addr[3:0];
        return cmd;
    endfunction

    assign nextAddr = (scanAddr == charAddrT'(charDepth - 1)) ? '0 : scanAddr + 1'b1;
    assign readAddr = scanAddr;

    always_comb
    begin
        req.valid = reqValid;
        req.word = reqWord;
        req.rs = dataPhase;
        req.hold = refreshHold;
    end

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            scanAddr <= '0;
            dataPhase <= 1'b0;
            reqValid <= 1'b0;
        end
        else if (!reqValid)
        begin
            // first request only once init is through
            if (initDone)
            begin
                reqValid <= 1'b1;
            end
        end
        else if (done)
        begin
            if (dataPhase)
            begin
                scanAddr <= nextAddr;
            end
            dataPhase <= !dataPhase;
        end
    end

    // word for the pending request, held until its done
    always_ff @(posedge clk)
    begin
        if (!reqValid)
        begin
            reqWord <= addrCommand(scanAddr);
        end
        else if (done && !dataPhase)
        begin
            // read port has settled on scanAddr long before this
            reqWord.raw <= readData;
        end
        else if (done)
        begin
            reqWord <= addrCommand(nextAddr);
        end
    end

endmodule

// File: src/lcdBusArbiter.sv
`timescale 1ns/1ns

module lcdBusArbiter
    import lcdCmdPkg::*;
(
    input  logic   clk,
    input  logic   lcdOnIn,
    input  busReqT initReq,
    input  busReqT scanReq,
    input  logic   engineBusy,
    output busReqT grantReq,
    input  logic   engineDone,
    output logic   initDoneAck,
    output logic   scanDoneAck
);

    logic grantInit;
    logic grantScan;

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            grantInit <= 1'b0;
            grantScan <= 1'b0;
        end
        else if (engineDone)
        begin
            grantInit <= 1'b0;
            grantScan <= 1'b0;
        end
        else if (!grantInit && !grantScan && !engineBusy)
        begin
            // init always wins
            grantInit <= initReq.valid;
            grantScan <= !initReq.valid && scanReq.valid;
        end
    end

    always_comb
    begin
        if (grantInit)
        begin
            grantReq = initReq;
        end
        else if (grantScan)
        begin
            grantReq = scanReq;
        end
        else
        begin
            grantReq = '0;
        end
    end

    // done goes back to the owner only
    assign initDoneAck = engineDone && grantInit;
    assign scanDoneAck = engineDone && grantScan;

    // owner stays put for the whole engine cycle
    grantHeldWhileBusy: assert property (
        @(posedge clk) disable iff (!lcdOnIn)
        engineBusy |-> $onehot({grantInit, grantScan})
    );

endmodule

// File: src/busCycleEngine.sv
`timescale 1ns/1ns

module busCycleEngine
    import lcdTimingPkg::*;
    import lcdCmdPkg::*;
(
    input  logic    clk,
    input  logic    lcdOnIn,
    input  busReqT  req,
    output logic    busy,
    output logic    done,
    output lcdWordU lcdBus,
    output logic    lcdRs,
    output logic    lcdEnable
);

    logic [1:0] phase;
    cycleCountT count;
    cycleCountT holdLen;

    assign busy = (phase != phaseIdle);
    assign done = (phase == phaseHold) && (count == holdLen - 1'b1);

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            phase <= phaseIdle;
            count <= '0;
            lcdBus <= '0;
            lcdRs <= 1'b0;
            lcdEnable <= 1'b0;
        end
        else
        begin
            case (phase)
                phaseIdle:
                begin
                    if (req.valid)
                    begin
                        // bus and rs settle before enable rises
                        phase <= phaseSetup;
                        count <= '0;
                        lcdBus <= req.word;
                        lcdRs <= req.rs;
                    end
                end
                phaseSetup:
                begin
                    if (count == setupLen - 1'b1)
                    begin
                        phase <= phasePulse;
                        count <= '0;
                        lcdEnable <= 1'b1;
                    end
                    else
                    begin
                        count <= count + 1'b1;
                    end
                end
                phasePulse:
                begin
                    if (count == enablePulseLen - 1'b1)
                    begin
                        phase <= phaseHold;
                        count <= '0;
                        lcdEnable <= 1'b0;
                    end
                    else
                    begin
                        count <= count + 1'b1;
                    end
                end
                default:
                begin
                    // panel executes the word, bus keeps its value
                    if (done)
                    begin
                        phase <= phaseIdle;
                        count <= '0;
                    end
                    else
                    begin
                        count <= count + 1'b1;
                    end
                end
            endcase
        end
    end

    // hold time of the accepted request
    always_ff @(posedge clk)
    begin
        if (phase == phaseIdle && req.valid)
        begin
            holdLen <= req.hold;
        end
    end

    // panel latches on the falling edge, word must not move under enable
    busStableUnderEnable: assert property (
        @(posedge clk) disable iff (!lcdOnIn) lcdEnable |-> $stable(lcdBus.raw)
    );

endmodule

// File: src/lcdController.sv
`timescale 1ns/1ns

module lcdController
    import lcdCmdPkg::*;
(
    input  logic       clk,
    input  logic       lcdOnIn,
    input  logic       writeEnable,
    input  charAddrT   writeAddr,
    input  logic [7:0] charCode,
    output logic [7:0] lcdBus,
    output logic       lcdOnOut,
    output logic       lcdRs,
    output logic       lcdEnable
);

    hostWriteT  hostWrite;
    charAddrT   readAddr;
    logic [7:0] readData;
    busReqT     initReq;
    busReqT     scanReq;
    busReqT     grantReq;
    logic       initDone;
    logic       initDoneAck;
    logic       scanDoneAck;
    logic       engineBusy;
    logic       engineDone;
    lcdWordU    engineBus;

    assign hostWrite = '{strobe: writeEnable, addr: writeAddr, code: charCode};
    assign lcdBus = engineBus.raw;

    // panel power follows the switch
    assign lcdOnOut = lcdOnIn;

    charMemory i_charMemory (
        .clk       (clk),
        .hostWrite (hostWrite),
        .readAddr  (readAddr),
        .readData  (readData)
    );

    initSequencer i_initSequencer (
        .clk      (clk),
        .lcdOnIn  (lcdOnIn),
        .req      (initReq),
        .done     (initDoneAck),
        .initDone (initDone)
    );

    refreshScanner i_refreshScanner (
        .clk      (clk),
        .lcdOnIn  (lcdOnIn),
        .initDone (initDone),
        .req      (scanReq),
        .done     (scanDoneAck),
        .readAddr (readAddr),
        .readData (readData)
    );

    lcdBusArbiter i_lcdBusArbiter (
        .clk         (clk),
        .lcdOnIn     (lcdOnIn),
        .initReq     (initReq),
        .scanReq     (scanReq),
        .engineBusy  (engineBusy),
        .grantReq    (grantReq),
        .engineDone  (engineDone),
        .initDoneAck (initDoneAck),
        .scanDoneAck (scanDoneAck)
    );

    busCycleEngine i_busCycleEngine (
        .clk       (clk),
        .lcdOnIn   (lcdOnIn),
        .req       (grantReq),
        .busy      (engineBusy),
        .done      (engineDone),
        .lcdBus    (engineBus),
        .lcdRs     (lcdRs),
        .lcdEnable (lcdEnable)
    );

endmodule

// File: dv/lcdControllerTb.sv
`timescale 1ns/1ns

module lcdControllerTb
    import lcdTimingPkg::*;
    import lcdCmdPkg::*;
;

    typedef struct packed {
        lcdWordU    word;
        logic       rs;
    } busEventT;

    // HD44780 init order
    localparam logic [7:0] initWords [8] = '{
        8'h38, 8'h38, 8'h38, 8'h38, 8'h08, 8'h01, 8'h06, 8'h0C
    };
    localparam int expPowerOnWait = 1_000_000;
    localparam cycleCountT expPulseLen = 24'd27;
    localparam int driveDelay = 10;

    // limit covers three init runs and four refresh passes with 10% margin
    localparam int initCycles = 1_000_000 + 3 * 250_000 + 3 * 7_500 + 2 * 2_500 + 8 * 30;
    localparam int passCycles = 64 * 55;
    localparam int timeoutLimit = (3 * initCycles + 4 * passCycles) * 11 / 10;

    logic       clk;
    logic       lcdOnIn;
    logic       writeEnable;
    charAddrT   writeAddr;
    logic [7:0] charCode;
    logic [7:0] lcdBus;
    logic       lcdOnOut;
    logic       lcdRs;
    logic       lcdEnable;

    busEventT   events[$];
    cycleCountT pulseLog[$];
    logic [7:0] model [charDepth];
    lcdWordU    passData [charDepth];
    logic       passRs [charDepth];
    logic       prevEnable;
    logic       seenRise;
    cycleCountT highCount;
    int         lowSinceReset;
    int         idleBeforeFirst;
    int         cycleCount = 0;
    int         errorCount = 0;
    int         testsRun = 0;
    int         testsFailed = 0;
    int         testErrorsAtStart;
    string      curTest;

    lcdController i_lcdController (
        .clk         (clk),
        .lcdOnIn     (lcdOnIn),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .charCode    (charCode),
        .lcdBus      (lcdBus),
        .lcdOnOut    (lcdOnOut),
        .lcdRs       (lcdRs),
        .lcdEnable   (lcdEnable)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutLimit)
        begin
            $display("timeout after %0d cycles, DUT stopped producing bus cycles", cycleCount);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // bus monitor records one entry per falling edge of enable
    always @(negedge clk)
    begin
        if (!lcdOnIn)
        begin
            prevEnable = 1'b0;
            seenRise = 1'b0;
            highCount = '0;
            lowSinceReset = 0;
            events.delete();
        end
        else
        begin
            if (lcdEnable)
            begin
                highCount = highCount + 1'b1;
            end
            if (prevEnable && !lcdEnable)
            begin
                events.push_back('{word: lcdBus, rs: lcdRs});
                pulseLog.push_back(highCount);
                highCount = '0;
            end
            if (!seenRise)
            begin
                if (lcdEnable)
                begin
                    seenRise = 1'b1;
                    idleBeforeFirst = lowSinceReset;
                end
                else
                begin
                    lowSinceReset = lowSinceReset + 1;
                end
            end
            prevEnable = lcdEnable;
        end
    end

    task automatic reportFailure(input string msg);
        $display("%s: %s", curTest, msg);
        errorCount++;
    endtask

    task automatic checkWord(input string testName, input lcdWordU expWord, input logic expRs,
                             input lcdWordU actWord, input logic actRs);
        if (actWord !== expWord || actRs !== expRs)
        begin
            $display("CHECK FAILED %s: expected word 0x%02h rs %0b, actual word 0x%02h rs %0b",
                     testName, expWord.raw, expRs, actWord.raw, actRs);
            errorCount++;
        end
    endtask

    task automatic checkPulse(input string testName, input cycleCountT expLen,
                              input cycleCountT actLen);
        if (actLen !== expLen)
        begin
            $display("CHECK FAILED %s: expected pulse %0d cycles, actual %0d cycles",
                     testName, expLen, actLen);
            errorCount++;
        end
    endtask

    task automatic checkBit(input string testName, input logic expBit, input logic actBit);
        if (actBit !== expBit)
        begin
            $display("CHECK FAILED %s: expected %0b, actual %0b", testName, expBit, actBit);
            errorCount++;
        end
    endtask

    task automatic beginTest(input string name);
        curTest = name;
        testErrorsAtStart = errorCount;
    endtask

    task automatic finishTest();
        testsRun++;
        if (errorCount > testErrorsAtStart)
        begin
            testsFailed++;
            $display("test %s: FAILED with %0d errors", curTest, errorCount - testErrorsAtStart);
        end
        else
        begin
            $display("test %s: passed", curTest);
        end
    endtask

    task automatic popEvent(output busEventT ev);
        while (events.size() == 0)
        begin
            @(posedge clk);
        end
        ev = events.pop_front();
    endtask

    task automatic writeChar(input charAddrT addr, input logic [7:0] code);
        @(posedge clk);
        #driveDelay;
        writeEnable = 1'b1;
        writeAddr = addr;
        charCode = code;
        model[addr] = code;
        @(posedge clk);
        #driveDelay;
        writeEnable = 1'b0;
    endtask

    // line two starts at DDRAM 0x40
    function automatic lcdWordU ddramWordFor(input int addr);
        lcdWordU w;
        w = 8'h80 + ((addr >= 16) ? 8'h40 : 8'h00) + 8'(addr % 16);
        return w;
    endfunction

    task automatic initSequenceTest(input string name);
        busEventT ev;
        beginTest(name);
        for (int i = 0; i < 8; i++)
        begin
            popEvent(ev);
            checkWord($sformatf("%s cmd %0d", name, i), initWords[i], 1'b0, ev.word, ev.rs);
        end
        if (idleBeforeFirst < expPowerOnWait)
        begin
            reportFailure($sformatf("lcdEnable rose after only %0d cycles of power-on wait",
                                    idleBeforeFirst));
        end
        finishTest();
    endtask

    // checks the address commands and keeps the data words for later
    task automatic collectPass(input string name);
        busEventT ev;
        beginTest(name);
        for (int a = 0; a < charDepth; a++)
        begin
            popEvent(ev);
            checkWord($sformatf("%s addr %0d", name, a), ddramWordFor(a), 1'b0, ev.word, ev.rs);
            popEvent(ev);
            passData[a] = ev.word;
            passRs[a] = ev.rs;
        end
        finishTest();
    endtask

    task automatic checkPassData(input string name);
        beginTest(name);
        for (int a = 0; a < charDepth; a++)
        begin
            checkWord($sformatf("%s data %0d", name, a), model[a], 1'b1, passData[a], passRs[a]);
        end
        finishTest();
    endtask

    task automatic rewriteDuringPass();
        busEventT ev;
        charAddrT addr;
        repeat (10)
        begin
            popEvent(ev);
        end
        repeat (8)
        begin
            addr = charAddrT'($urandom % 32);
            writeChar(addr, 8'($urandom));
        end
        // drop the rest of the running pass
        forever
        begin
            while (events.size() == 0)
            begin
                @(posedge clk);
            end
            if (events[0].word.raw == 8'h80 && !events[0].rs)
            begin
                break;
            end
            void'(events.pop_front());
        end
    endtask

    task automatic powerCycleMidRefresh(input string name);
        beginTest(name);
        do
        begin
            @(negedge clk);
        end
        while (!lcdEnable);
        @(posedge clk);
        #driveDelay;
        lcdOnIn = 1'b0;
        #1;
        checkBit($sformatf("%s lcdEnable", name), 1'b0, lcdEnable);
        checkBit($sformatf("%s lcdOnOut", name), 1'b0, lcdOnOut);
        repeat (5)
        begin
            @(posedge clk);
        end
        #driveDelay;
        lcdOnIn = 1'b1;
        finishTest();
    endtask

    task automatic pulseLengthTest(input string name);
        beginTest(name);
        foreach (pulseLog[i])
        begin
            checkPulse($sformatf("%s pulse %0d", name, i), expPulseLen, pulseLog[i]);
        end
        finishTest();
    endtask

    initial
    begin
        lcdOnIn = 1'b0;
        writeEnable = 1'b0;
        writeAddr = '0;
        charCode = '0;
        void'($urandom(45));
        repeat (5)
        begin
            @(posedge clk);
        end
        #driveDelay;
        lcdOnIn = 1'b1;

        // fill memory long before the power-on wait ends
        for (int a = 0; a < charDepth; a++)
        begin
            writeChar(charAddrT'(a), 8'($urandom));
        end

        initSequenceTest("init sequence");
        collectPass("first pass addresses");
        checkPassData("random codes");
        rewriteDuringPass();
        collectPass("next pass addresses");
        checkPassData("rewritten codes");
        powerCycleMidRefresh("power off mid refresh");
        initSequenceTest("init after power cycle");
        collectPass("pass after power cycle");
        checkPassData("memory retained");
        pulseLengthTest("enable pulse length");

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: build.f
src/lcdTimingPkg.sv
src/lcdCmdPkg.sv
src/charMemory.sv
src/initSequencer.sv
src/refreshScanner.sv
src/lcdBusArbiter.sv
src/busCycleEngine.sv
src/lcdController.sv
dv/lcdControllerTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module lcdControllerTb -o lcdControllerSim

status=0
./obj_dir/lcdControllerSim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
